/* src/usb_fe_cfg.svh */
`ifndef USB_FE_CFG_SVH
`define USB_FE_CFG_SVH

// timer and wait value width, one word
`define USB_FE_COUNTER_WIDTH 24

// register port data width
`define USB_FE_REG_WIDTH 32

// register map on the 2-bit address
`define USB_FE_ADDR_CTRL   2'd0
`define USB_FE_ADDR_WAIT1  2'd1
`define USB_FE_ADDR_WAIT2  2'd2
`define USB_FE_ADDR_STATUS 2'd3

`endif

/* src/usb_speed_pkg.sv */
`default_nettype none

package usb_speed_pkg;

    // detected speed, AUTO means not yet determined
    typedef enum logic [1:0] {
        SPEED_AUTO = 2'd0,
        SPEED_LS   = 2'd1,
        SPEED_FS   = 2'd2,
        SPEED_HS   = 2'd3
    } usb_speed_e;

    // line state as {linestate1, linestate0}
    typedef enum logic [1:0] {
        LINE_SE0 = 2'b00,
        LINE_J   = 2'b01,
        LINE_K   = 2'b10,
        LINE_SE1 = 2'b11   // illegal on the bus, used to park the detector
    } usb_linestate_e;

endpackage

`default_nettype wire

/* src/usb_reg_pkg.sv */
`default_nettype none
`include "usb_fe_cfg.svh"

package usb_reg_pkg;

    // one write word, read as control or as a wait count
    typedef union packed {
        struct packed {
            logic [`USB_FE_REG_WIDTH-2:0] rsvd;
            logic                         restart;   // bit 0
        } ctrl;
        struct packed {
            logic [`USB_FE_REG_WIDTH-`USB_FE_COUNTER_WIDTH-1:0] pad;
            logic [`USB_FE_COUNTER_WIDTH-1:0]                   count;
        } delay;
    } reg_word_u;

endpackage

`default_nettype wire

/* src/usb_reg_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "usb_fe_cfg.svh"

module usb_reg_decode
    import usb_speed_pkg::*, usb_reg_pkg::*;
(
    input  wire logic                             cwusb_clk,
    input  wire logic                             reset_i,
    input  wire logic [1:0]                       reg_addr,
    input  wire logic                             reg_write,
    input  wire reg_word_u                        reg_wdata,
    output logic      [`USB_FE_REG_WIDTH-1:0]     reg_rdata,
    output logic      [`USB_FE_COUNTER_WIDTH-1:0] wait1,
    output logic      [`USB_FE_COUNTER_WIDTH-1:0] wait2,
    output logic                                  restart_req,
    input  wire usb_speed_e                       speed_sync,
    input  wire logic                             done
);

    localparam int PAD_W = `USB_FE_REG_WIDTH - `USB_FE_COUNTER_WIDTH;

    //////////////////////////////////////////////////
    // writes
    //////////////////////////////////////////////////

    always_ff @(posedge cwusb_clk) begin
        if (reset_i) begin
            wait1       <= '0;
            wait2       <= '0;
            restart_req <= 1'b0;
        end else begin
            restart_req <= 1'b0;   // single cycle unless a ctrl write
            if (reg_write) begin
                case (reg_addr)
                    `USB_FE_ADDR_CTRL:  restart_req <= reg_wdata.ctrl.restart;
                    `USB_FE_ADDR_WAIT1: wait1 <= reg_wdata.delay.count;
                    `USB_FE_ADDR_WAIT2: wait2 <= reg_wdata.delay.count;
                    default: ;    // status is read only
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // reads are combinational from the address
    //////////////////////////////////////////////////

    always_comb begin
        case (reg_addr)
            `USB_FE_ADDR_WAIT1:  reg_rdata = {{PAD_W{1'b0}}, wait1};
            `USB_FE_ADDR_WAIT2:  reg_rdata = {{PAD_W{1'b0}}, wait2};
            `USB_FE_ADDR_STATUS: reg_rdata = {{(`USB_FE_REG_WIDTH-3){1'b0}}, done, speed_sync};
            default:             reg_rdata = '0;   // restart bit reads back as zero
        endcase
    end

endmodule

`default_nettype wire

/* src/cdc_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

module cdc_pulse (
    input  wire logic reset_i,
    input  wire logic src_clk,
    input  wire logic src_pulse,
    input  wire logic dst_clk,
    output logic      dst_pulse
);

    logic       src_toggle;
    logic [2:0] dst_sync;   // [0] is the metastable stage

    // source side flips once per pulse
    always_ff @(posedge src_clk) begin
        if (reset_i)
            src_toggle <= 1'b0;
        else if (src_pulse)
            src_toggle <= ~src_toggle;
    end

    always_ff @(posedge dst_clk) begin
        if (reset_i)
            dst_sync <= '0;
        else
            dst_sync <= {dst_sync[1:0], src_toggle};
    end

    // any edge of the synced toggle is one pulse
    assign dst_pulse = dst_sync[2] ^ dst_sync[1];

endmodule

`default_nettype wire

/* src/usb_autodetect.sv */
`timescale 1ns/1ps
`default_nettype none
`include "usb_fe_cfg.svh"

module usb_autodetect
    import usb_speed_pkg::*;
(
    input  wire logic                             fe_clk,
    input  wire logic                             reset_i,
    input  wire logic                             fe_linestate0,
    input  wire logic                             fe_linestate1,
    input  wire logic                             restart,
    input  wire logic [`USB_FE_COUNTER_WIDTH-1:0] wait1,
    input  wire logic [`USB_FE_COUNTER_WIDTH-1:0] wait2,
    output usb_speed_e                            speed
);

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_LS       = 3'd1,
        ST_FS       = 3'd2,
        ST_HS       = 3'd3,
        ST_DONE     = 3'd4,
        ST_ERROR    = 3'd5,
        ST_FSHS     = 3'd6,
        ST_WAIT_LOW = 3'd7
    } state_e;

    state_e state;
    state_e next_state;
    state_e prev_state;   // where DONE was entered from

    logic [`USB_FE_COUNTER_WIDTH-1:0] timer;
    logic [`USB_FE_COUNTER_WIDTH-1:0] wait1_q;
    logic [`USB_FE_COUNTER_WIDTH-1:0] wait2_q;

    usb_linestate_e linestate;

    assign linestate = usb_linestate_e'({fe_linestate1, fe_linestate0});

    // quasi-static from the register port
    always_ff @(posedge fe_clk) begin
        wait1_q <= wait1;
        wait2_q <= wait2;
    end

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_ff @(posedge fe_clk) begin
        if (reset_i)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (linestate == LINE_K)
                    next_state = ST_LS;
                else if (linestate == LINE_J)
                    next_state = ST_FSHS;
            end
            ST_LS: begin
                if (linestate != LINE_K)
                    next_state = ST_ERROR;   // K broke before wait1
                else if (timer == wait1_q)
                    next_state = ST_DONE;
            end
            ST_FSHS: begin
                if (linestate != LINE_J)
                    next_state = ST_ERROR;
                else if (timer == wait1_q)
                    next_state = ST_WAIT_LOW;
            end
            ST_WAIT_LOW: begin
                if (linestate == LINE_SE0)
                    next_state = ST_HS;
                else if (linestate != LINE_J)
                    next_state = ST_ERROR;
            end
            ST_HS: begin
                // SE0 long enough means the device pulled to HS
                if (timer == wait2_q)
                    next_state = ST_DONE;
                else if (linestate == LINE_J)
                    next_state = ST_FS;
                else if (linestate == LINE_K)
                    next_state = ST_ERROR;
            end
            ST_FS:    next_state = ST_DONE;
            ST_DONE: begin
                if (restart)
                    next_state = ST_IDLE;
            end
            ST_ERROR: next_state = ST_IDLE;
            default:  next_state = ST_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // timer
    //////////////////////////////////////////////////

    always_ff @(posedge fe_clk) begin
        if (reset_i)
            timer <= '0;
        else if (state == ST_IDLE || state == ST_WAIT_LOW || restart)
            timer <= '0;
        else if (state == ST_LS || state == ST_FSHS || state == ST_HS)
            timer <= timer + 1'b1;
    end

    // speed follows DONE by one cycle
    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            prev_state <= ST_IDLE;
            speed      <= SPEED_AUTO;
        end else begin
            prev_state <= state;
            if (state == ST_IDLE || state == ST_ERROR) begin
                speed <= SPEED_AUTO;
            end else if (state == ST_DONE) begin
                case (prev_state)
                    ST_LS:   speed <= SPEED_LS;
                    ST_FS:   speed <= SPEED_FS;
                    ST_HS:   speed <= SPEED_HS;
                    default: ;   // already announced, hold
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/usb_speed_report.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_speed_report
    import usb_speed_pkg::*;
(
    input  wire logic       fe_clk,
    input  wire logic       cwusb_clk,
    input  wire logic       reset_i,
    input  wire usb_speed_e speed,
    input  wire logic       restart_req,
    output usb_speed_e      speed_sync,
    output logic            done
);

    usb_speed_e speed_launch;   // glitch free source on the fe_clk side
    usb_speed_e sync_a;
    usb_speed_e sync_b;
    logic       armed;          // AUTO seen since last restart

    always_ff @(posedge fe_clk) begin
        if (reset_i)
            speed_launch <= SPEED_AUTO;
        else
            speed_launch <= speed;
    end

    //////////////////////////////////////////////////
    // cwusb_clk side
    //////////////////////////////////////////////////

    always_ff @(posedge cwusb_clk) begin
        if (reset_i) begin
            sync_a     <= SPEED_AUTO;
            sync_b     <= SPEED_AUTO;
            speed_sync <= SPEED_AUTO;
        end else begin
            sync_a <= speed_launch;
            sync_b <= sync_a;
            if (sync_a == sync_b)   // both bits settled
                speed_sync <= sync_b;
        end
    end

    // sticky done ignores a stale result until AUTO comes back
    always_ff @(posedge cwusb_clk) begin
        if (reset_i) begin
            armed <= 1'b1;
            done  <= 1'b0;
        end else if (restart_req) begin
            armed <= 1'b0;
            done  <= 1'b0;
        end else if (speed_sync == SPEED_AUTO) begin
            armed <= 1'b1;
        end else if (armed) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/usb_fe_autodetect_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "usb_fe_cfg.svh"

module usb_fe_autodetect_top
    import usb_speed_pkg::*;
(
    input  wire logic                         fe_clk,
    input  wire logic                         cwusb_clk,
    input  wire logic                         reset_i,
    input  wire logic                         fe_linestate0,
    input  wire logic                         fe_linestate1,
    input  wire logic [1:0]                   reg_addr,
    input  wire logic                         reg_write,
    input  wire logic [`USB_FE_REG_WIDTH-1:0] reg_wdata,
    output logic      [`USB_FE_REG_WIDTH-1:0] reg_rdata
);

    logic [`USB_FE_COUNTER_WIDTH-1:0] wait1;
    logic [`USB_FE_COUNTER_WIDTH-1:0] wait2;
    logic                             restart_req;   // cwusb_clk
    logic                             restart;       // fe_clk
    usb_speed_e                       speed;
    usb_speed_e                       speed_sync;
    logic                             done;

    usb_reg_decode i_reg_decode (
        .cwusb_clk   (cwusb_clk),
        .reset_i     (reset_i),
        .reg_addr    (reg_addr),
        .reg_write   (reg_write),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .wait1       (wait1),
        .wait2       (wait2),
        .restart_req (restart_req),
        .speed_sync  (speed_sync),
        .done        (done)
    );

    cdc_pulse i_restart_cdc (
        .reset_i   (reset_i),
        .src_clk   (cwusb_clk),
        .src_pulse (restart_req),
        .dst_clk   (fe_clk),
        .dst_pulse (restart)
    );

    usb_autodetect i_autodetect (
        .fe_clk        (fe_clk),
        .reset_i       (reset_i),
        .fe_linestate0 (fe_linestate0),
        .fe_linestate1 (fe_linestate1),
        .restart       (restart),
        .wait1         (wait1),
        .wait2         (wait2),
        .speed         (speed)
    );

    usb_speed_report i_speed_report (
        .fe_clk      (fe_clk),
        .cwusb_clk   (cwusb_clk),
        .reset_i     (reset_i),
        .speed       (speed),
        .restart_req (restart_req),
        .speed_sync  (speed_sync),
        .done        (done)
    );

endmodule

`default_nettype wire

/* testbench/usb_autodetect_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_autodetect_sva
    import usb_speed_pkg::*;
(
    input  wire logic       fe_clk,
    input  wire logic       reset_i,
    input  wire logic       restart,
    input  wire logic [2:0] state,
    input  wire usb_speed_e speed
);

    // encodings of the detector FSM
    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_DONE = 3'd4;

    int fail_count = 0;   // assertion failures so far

    // speed lags the state by one cycle
    idle_gives_auto: assert property (@(posedge fe_clk) disable iff (reset_i)
        (state == ST_IDLE) |=> (speed == SPEED_AUTO))
    else begin
        $error("speed not AUTO one cycle after IDLE");
        fail_count++;
    end

    done_holds_speed: assert property (@(posedge fe_clk) disable iff (reset_i)
        (state == ST_DONE && $past(state) == ST_DONE && !restart) |=> $stable(speed))
    else begin
        $error("speed changed while the FSM sat in DONE");
        fail_count++;
    end

    state_known: assert property (@(posedge fe_clk) disable iff (reset_i)
        !$isunknown({state, speed}))
    else begin
        $error("FSM state or speed holds an unknown code");
        fail_count++;
    end

endmodule

bind usb_autodetect usb_autodetect_sva i_sva (
    .fe_clk  (fe_clk),
    .reset_i (reset_i),
    .restart (restart),
    .state   (state),
    .speed   (speed)
);

`default_nettype wire

/* testbench/usb_autodetect_checker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "usb_fe_cfg.svh"

module usb_autodetect_checker
    import usb_speed_pkg::*;
(
    input  wire logic                         cwusb_clk,
    input  wire logic                         reset_i,
    input  wire logic [1:0]                   reg_addr,
    input  wire logic [`USB_FE_REG_WIDTH-1:0] reg_rdata,
    input  wire logic                         check_req,   // one cwusb_clk cycle
    input  wire usb_speed_e                   exp_speed,
    input  wire logic                         exp_done,
    input  var int                            row,
    output int                                check_count,
    output int                                error_count
);

    always @(posedge cwusb_clk) begin : compare
        int errs;
        errs = 0;
        if (reset_i) begin
            check_count <= 0;
            error_count <= 0;
        end else if (check_req) begin
            if (reg_addr != `USB_FE_ADDR_STATUS) begin
                $display("Row %0d: the register port was not addressing STATUS at the check",
                         row);
                errs++;
            end else begin
                if (reg_rdata[1:0] != exp_speed) begin
                    $display("Mismatch at %0t: row %0d field speed read %0d, expected %0d",
                             $time, row, reg_rdata[1:0], exp_speed);
                    errs++;
                end
                if (reg_rdata[2] != exp_done) begin
                    $display("Mismatch at %0t: row %0d field done read %0b, expected %0b",
                             $time, row, reg_rdata[2], exp_done);
                    errs++;
                end
                if (reg_rdata[`USB_FE_REG_WIDTH-1:3] != '0) begin   // upper bits read zero
                    $display("Mismatch at %0t: row %0d field reserved read nonzero %h",
                             $time, row, reg_rdata);
                    errs++;
                end
            end
            check_count <= check_count + 1;
            error_count <= error_count + errs;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_usb_autodetect.sv */
`timescale 1ns/1ps
`default_nettype none
`include "usb_fe_cfg.svh"

module tb_usb_autodetect
    import usb_speed_pkg::*;
();

    localparam int NUM_ROWS   = 10;
    localparam int MAX_PHASES = 3;

    logic                         fe_clk = 1'b0;
    logic                         cwusb_clk = 1'b0;
    logic                         reset_i;
    logic                         fe_linestate0;
    logic                         fe_linestate1;
    logic [1:0]                   reg_addr;
    logic                         reg_write;
    logic [`USB_FE_REG_WIDTH-1:0] reg_wdata;
    logic [`USB_FE_REG_WIDTH-1:0] reg_rdata;

    logic        check_req;
    usb_speed_e  exp_speed;
    logic        exp_done;
    int          cur_row;
    int          check_count;
    int          error_count;
    int          cycle_count = 0;
    int          cycle_limit;
    int unsigned seed_val;

    // stimulus table, one detection per row
    int unsigned    row_wait1  [NUM_ROWS];
    int unsigned    row_wait2  [NUM_ROWS];
    int             row_phases [NUM_ROWS];
    usb_linestate_e row_line   [NUM_ROWS][MAX_PHASES];
    int unsigned    row_len    [NUM_ROWS][MAX_PHASES];
    usb_speed_e     row_speed  [NUM_ROWS];

    always #50 fe_clk = ~fe_clk;
    always #70 cwusb_clk = ~cwusb_clk;

    usb_fe_autodetect_top i_dut (
        .fe_clk        (fe_clk),
        .cwusb_clk     (cwusb_clk),
        .reset_i       (reset_i),
        .fe_linestate0 (fe_linestate0),
        .fe_linestate1 (fe_linestate1),
        .reg_addr      (reg_addr),
        .reg_write     (reg_write),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata)
    );

    usb_autodetect_checker i_checker (
        .cwusb_clk   (cwusb_clk),
        .reset_i     (reset_i),
        .reg_addr    (reg_addr),
        .reg_rdata   (reg_rdata),
        .check_req   (check_req),
        .exp_speed   (exp_speed),
        .exp_done    (exp_done),
        .row         (cur_row),
        .check_count (check_count),
        .error_count (error_count)
    );

    //////////////////////////////////////////////////
    // table building
    //////////////////////////////////////////////////

    task automatic load_row(input int r, input int w1, input int w2, input int n,
                            input usb_linestate_e l0, input int n0,
                            input usb_linestate_e l1, input int n1,
                            input usb_linestate_e l2, input int n2, input usb_speed_e spd);
        row_wait1[r]   = w1;
        row_wait2[r]   = w2;
        row_phases[r]  = n;
        row_line[r][0] = l0;
        row_len[r][0]  = n0;
        row_line[r][1] = l1;
        row_len[r][1]  = n1;
        row_line[r][2] = l2;
        row_len[r][2]  = n2;
        row_speed[r]   = spd;
    endtask

    // K past wait1 is LS, J past wait1 then SE0 past wait2 is HS,
    // J past wait1 then short SE0 then J again is FS
    function automatic usb_speed_e predict_speed(input int r);
        if (row_phases[r] >= 1 && row_line[r][0] == LINE_K && row_len[r][0] > row_wait1[r])
            return SPEED_LS;
        if (row_phases[r] >= 2 && row_line[r][0] == LINE_J && row_len[r][0] > row_wait1[r]
            && row_line[r][1] == LINE_SE0) begin
            if (row_len[r][1] > row_wait2[r])
                return SPEED_HS;
            if (row_phases[r] == 3 && row_line[r][2] == LINE_J)
                return SPEED_FS;
        end
        return SPEED_AUTO;
    endfunction

    // kind 0 is LS, 1 is HS, 2 is FS
    task automatic make_random_row(input int r, input int kind);
        int unsigned extra;
        row_wait1[r]   = 8 + $urandom % 33;
        row_wait2[r]   = 8 + $urandom % 33;
        extra          = 3 + $urandom % 8;   // margin past the wait
        row_phases[r]  = kind + 1;
        row_line[r][0] = (kind == 0) ? LINE_K : LINE_J;
        row_len[r][0]  = row_wait1[r] + extra;
        row_line[r][1] = LINE_SE0;
        if (kind == 1)
            row_len[r][1] = row_wait2[r] + extra;
        else
            row_len[r][1] = 1 + $urandom % (row_wait2[r] - 3);
        row_line[r][2] = LINE_J;
        row_len[r][2]  = 2 + $urandom % 4;
        row_speed[r]   = predict_speed(r);
    endtask

    //////////////////////////////////////////////////
    // bus actions
    //////////////////////////////////////////////////

    task automatic write_reg(input logic [1:0] addr, input logic [`USB_FE_REG_WIDTH-1:0] data);
        @(posedge cwusb_clk);
        reg_addr  <= addr;
        reg_wdata <= data;
        reg_write <= 1'b1;
        @(posedge cwusb_clk);
        reg_write <= 1'b0;
        reg_addr  <= `USB_FE_ADDR_STATUS;   // park on status for the checker
        reg_wdata <= '0;
    endtask

    // called on a rising fe_clk, line is sampled on the next n edges
    task automatic drive_line(input usb_linestate_e ls, input int n);
        {fe_linestate1, fe_linestate0} <= ls;
        repeat (n) @(posedge fe_clk);
    endtask

    task automatic request_check(input usb_speed_e spd, input logic dn);
        @(posedge cwusb_clk);
        exp_speed <= spd;
        exp_done  <= dn;
        check_req <= 1'b1;
        @(posedge cwusb_clk);
        check_req <= 1'b0;
    endtask

    task automatic run_row(input int r);
        int p;
        cur_row = r;
        write_reg(`USB_FE_ADDR_WAIT1, row_wait1[r]);
        write_reg(`USB_FE_ADDR_WAIT2, row_wait2[r]);
        write_reg(`USB_FE_ADDR_CTRL, 32'h1);
        @(posedge fe_clk);
        drive_line(LINE_SE1, 20);           // hold off while restart crosses
        request_check(SPEED_AUTO, 1'b0);    // restart cleared the last result
        @(posedge fe_clk);
        for (p = 0; p < row_phases[r]; p++)
            drive_line(row_line[r][p], row_len[r][p]);
        drive_line(LINE_SE1, 20);           // settle
        request_check(row_speed[r], row_speed[r] != SPEED_AUTO);
    endtask

    function automatic int total_errors();
        return error_count + i_dut.i_autodetect.i_sva.fail_count;
    endfunction

    task automatic print_summary();
        $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
                 check_count, error_count, i_dut.i_autodetect.i_sva.fail_count);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int r;
        int p;
        seed_val      = $urandom(32'h1c70);
        reset_i       = 1'b1;
        fe_linestate1 = 1'b1;   // SE1 parks the detector
        fe_linestate0 = 1'b1;
        reg_addr      = `USB_FE_ADDR_STATUS;
        reg_write     = 1'b0;
        reg_wdata     = '0;
        check_req     = 1'b0;
        exp_speed     = SPEED_AUTO;
        exp_done      = 1'b0;
        cur_row       = 0;

        //       row w1  w2  n  phase0      phase1        phase2        expected
        load_row(0, 10, 12, 1, LINE_K, 14, LINE_SE1, 0, LINE_SE1, 0, SPEED_LS);
        load_row(1, 10, 12, 2, LINE_J, 14, LINE_SE0, 16, LINE_SE1, 0, SPEED_HS);
        load_row(2, 10, 12, 3, LINE_J, 14, LINE_SE0, 4, LINE_J, 4, SPEED_FS);
        load_row(3, 10, 12, 2, LINE_K, 5, LINE_J, 1, LINE_SE1, 0, SPEED_AUTO);  // error
        for (r = 4; r < NUM_ROWS; r++)
            make_random_row(r, (r - 4) % 3);

        cycle_limit = 200 * NUM_ROWS;
        for (r = 0; r < NUM_ROWS; r++)
            for (p = 0; p < row_phases[r]; p++)
                cycle_limit += row_len[r][p];

        repeat (4) @(posedge fe_clk);
        reset_i <= 1'b0;

        for (r = 0; r < NUM_ROWS; r++)
            run_row(r);

        @(posedge cwusb_clk);   // let the last count land
        print_summary();
        if (total_errors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    always @(posedge fe_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d fe_clk cycles", cycle_limit);
            print_summary();
            $display("Testbench failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/usb_speed_pkg.sv
src/usb_reg_pkg.sv
src/usb_reg_decode.sv
src/cdc_pulse.sv
src/usb_autodetect.sv
src/usb_speed_report.sv
src/usb_fe_autodetect_top.sv
testbench/usb_autodetect_sva.sv
testbench/usb_autodetect_checker.sv
testbench/tb_usb_autodetect.sv

/* Bender.yml */
package:
  name: usb_fe_autodetect

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/usb_speed_pkg.sv
      - src/usb_reg_pkg.sv
      - src/usb_reg_decode.sv
      - src/cdc_pulse.sv
      - src/usb_autodetect.sv
      - src/usb_speed_report.sv
      - src/usb_fe_autodetect_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/usb_autodetect_sva.sv
      - testbench/usb_autodetect_checker.sv
      - testbench/tb_usb_autodetect.sv
